// File: Bender.yml
package:
  name: clause_array

sources:
  - solver_dims_pkg.sv
  - clause_types_pkg.sv
  - learnt_slot_pick.sv
  - clause_ctrl.sv
  - clause_store.sv
  - clause_eval.sv
  - clause_array_top.sv
  - target: test
    files:
      - clause_array_assert.sv
      - tb_clause_array.sv

// File: clause_array_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent assertions on the clause array handshake and result outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module clause_array_assert (
    input logic clk,
    input logic rst_n_i,
    input logic ready_i,
    input logic eval_i,
    input logic done_i,
    input logic rd_valid_i,
    input logic unit_valid_i,
    input logic conflict_i
);
    timeunit 1ns;
    timeprecision 1ps;

    no_output_before_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        !ready_i |-> (!done_i && !rd_valid_i))
        else $error("done_o or rd_valid_o high while ready_o is low");

    // an accepted strobe yields done two edges later
    done_follows_eval: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_i == $past(eval_i && ready_i, 2))
        else $error("done_o does not match eval_i accepted two cycles earlier");

    unit_masked_by_conflict: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(unit_valid_i && conflict_i))
        else $error("unit_valid_o and conflict_o high together");

endmodule

bind clause_array_top clause_array_assert i_assert (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .ready_i      (ready_o),
    .eval_i       (eval_i),
    .done_i       (done_o),
    .rd_valid_i   (rd_valid_o),
    .unit_valid_i (unit_valid_o),
    .conflict_i   (conflict_o)
);

`default_nettype wire

// File: clause_array_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clause array top level, controller plus store, learnt pick and evaluator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module clause_array_top (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          wr_i,
    input  clause_types_pkg::clause_idx_t wr_idx_i,
    input  logic                          learnt_i,
    input  clause_types_pkg::lit_mask_t   clause_i,
    input  logic                          rd_i,
    input  clause_types_pkg::clause_idx_t rd_idx_i,
    input  logic                          eval_i,
    input  clause_types_pkg::var_vals_t   var_vals_i,
    output logic                          ready_o,
    output logic                          rd_valid_o,
    output clause_types_pkg::lit_mask_t   rd_clause_o,
    output logic                          done_o,
    output logic                          all_sat_o,
    output logic                          conflict_o,
    output logic                          unit_valid_o,
    output clause_types_pkg::var_idx_t    unit_var_o,
    output logic [1:0]                    unit_val_o
);

    logic                          store_we;
    clause_types_pkg::clause_idx_t store_idx;
    clause_types_pkg::lit_mask_t   store_data;
    logic                          clear_we;
    clause_types_pkg::clause_idx_t clear_idx;
    logic                          rd_en;
    logic                          eval_go;
    clause_types_pkg::clause_idx_t pick_idx;
    clause_types_pkg::lit_mask_t   clauses [solver_dims_pkg::num_clauses];
    clause_types_pkg::clause_len_t lens [solver_dims_pkg::num_clauses];

    clause_ctrl i_ctrl (
        .clk,
        .rst_n_i,
        .wr_i,
        .wr_idx_i,
        .learnt_i,
        .clause_i,
        .rd_i,
        .eval_i,
        .pick_idx_i   (pick_idx),
        .ready_o,
        .store_we_o   (store_we),
        .store_idx_o  (store_idx),
        .store_data_o (store_data),
        .clear_we_o   (clear_we),
        .clear_idx_o  (clear_idx),
        .rd_en_o      (rd_en),
        .eval_go_o    (eval_go)
    );

    clause_store i_store (
        .clk,
        .rst_n_i,
        .we_i        (store_we),
        .idx_i       (store_idx),
        .data_i      (store_data),
        .clear_we_i  (clear_we),
        .clear_idx_i (clear_idx),
        .rd_en_i     (rd_en),
        .rd_idx_i,
        .clauses_o   (clauses),
        .lens_o      (lens),
        .rd_valid_o,
        .rd_clause_o
    );

    learnt_slot_pick i_pick (
        .lens_i     (lens),
        .pick_idx_o (pick_idx)
    );

    clause_eval i_eval (
        .clk,
        .rst_n_i,
        .go_i         (eval_go),
        .vals_i       (var_vals_i),
        .clauses_i    (clauses),
        .done_o,
        .all_sat_o,
        .conflict_o,
        .unit_valid_o,
        .unit_var_o,
        .unit_val_o
    );

endmodule

`default_nettype wire

// File: clause_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clause array controller with the post-reset clear sequence,
// request gating and write slot selection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module clause_ctrl (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          wr_i,
    input  clause_types_pkg::clause_idx_t wr_idx_i,
    input  logic                          learnt_i,
    input  clause_types_pkg::lit_mask_t   clause_i,
    input  logic                          rd_i,
    input  logic                          eval_i,
    input  clause_types_pkg::clause_idx_t pick_idx_i,
    output logic                          ready_o,
    output logic                          store_we_o,
    output clause_types_pkg::clause_idx_t store_idx_o,
    output clause_types_pkg::lit_mask_t   store_data_o,
    output logic                          clear_we_o,
    output clause_types_pkg::clause_idx_t clear_idx_o,
    output logic                          rd_en_o,
    output logic                          eval_go_o
);

    clause_types_pkg::ctrl_state_t state_q;
    clause_types_pkg::clause_idx_t clr_cnt_q;
    logic                          clr_last;

    assign clr_last = (clr_cnt_q ==
        clause_types_pkg::clause_idx_t'(solver_dims_pkg::num_clauses - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clear sequence, one slot per cycle from slot 0 upwards
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= clause_types_pkg::st_clear;
            clr_cnt_q <= '0;
        end else if (state_q == clause_types_pkg::st_clear) begin
            clr_cnt_q <= clr_cnt_q + 1'b1;
            if (clr_last) begin
                state_q <= clause_types_pkg::st_run;   // last slot cleared on this edge
            end
        end
    end

    assign ready_o     = (state_q == clause_types_pkg::st_run);
    assign clear_we_o  = (state_q == clause_types_pkg::st_clear);
    assign clear_idx_o = clr_cnt_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request gating
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign store_we_o   = ready_o & wr_i;
    assign store_idx_o  = learnt_i ? pick_idx_i : wr_idx_i;  // learnt writes replace the longest
    assign store_data_o = clause_i;
    assign rd_en_o      = ready_o & rd_i;
    assign eval_go_o    = ready_o & eval_i;                  // strobes are dropped during the clear

endmodule

`default_nettype wire

// File: clause_eval.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-stage clause evaluator for satisfied, conflict and unit status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module clause_eval (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        go_i,
    input  clause_types_pkg::var_vals_t vals_i,
    input  clause_types_pkg::lit_mask_t clauses_i [solver_dims_pkg::num_clauses],
    output logic                        done_o,
    output logic                        all_sat_o,
    output logic                        conflict_o,
    output logic                        unit_valid_o,
    output clause_types_pkg::var_idx_t  unit_var_o,
    output logic [1:0]                  unit_val_o
);

    logic [solver_dims_pkg::num_clauses-1:0] sat_d;
    logic [solver_dims_pkg::num_clauses-1:0] fals_d;
    logic [solver_dims_pkg::num_clauses-1:0] unit_d;
    logic [solver_dims_pkg::num_clauses-1:0] upos_d;
    clause_types_pkg::var_idx_t              uvar_d [solver_dims_pkg::num_clauses];
    logic                                    s1_valid_q;
    logic [solver_dims_pkg::num_clauses-1:0] sat_q;
    logic [solver_dims_pkg::num_clauses-1:0] fals_q;
    logic [solver_dims_pkg::num_clauses-1:0] unit_q;
    logic [solver_dims_pkg::num_clauses-1:0] upos_q;
    clause_types_pkg::var_idx_t              uvar_q [solver_dims_pkg::num_clauses];
    logic                                    unit_ok;
    clause_types_pkg::var_idx_t              unit_var_d;
    logic                                    unit_pos_d;

    function automatic void clause_status(
        input  clause_types_pkg::lit_mask_t mask,
        input  clause_types_pkg::var_vals_t vals,
        output logic                        sat,
        output logic                        fals,
        output logic                        unit,
        output clause_types_pkg::var_idx_t  uvar,
        output logic                        upos
    );
        logic       any_true;
        logic [1:0] n_open;
        logic       is_t;
        logic       is_f;
        any_true = 1'b0;
        n_open   = 2'd0;
        uvar     = '0;
        upos     = 1'b0;
        for (int v = 0; v < solver_dims_pkg::num_vars; v++) begin
            is_t = (vals[2*v +: 2] == clause_types_pkg::val_true);
            is_f = (vals[2*v +: 2] == clause_types_pkg::val_false);
            if ((mask[2*v] && is_t) || (mask[2*v+1] && is_f)) begin
                any_true = 1'b1;
            end
            // open literals counted up to two, the positive one is taken last so it wins
            if (!is_t && !is_f) begin
                if (mask[2*v+1]) begin
                    n_open = (n_open == 2'd2) ? n_open : n_open + 2'd1;
                    uvar   = clause_types_pkg::var_idx_t'(v);
                    upos   = 1'b0;
                end
                if (mask[2*v]) begin
                    n_open = (n_open == 2'd2) ? n_open : n_open + 2'd1;
                    uvar   = clause_types_pkg::var_idx_t'(v);
                    upos   = 1'b1;
                end
            end
        end
        sat  = any_true || (mask == '0);                      // an empty slot never blocks
        fals = (mask != '0) && !any_true && (n_open == 2'd0);
        unit = !sat && (n_open == 2'd1);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 1 per-clause status
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int c = 0; c < solver_dims_pkg::num_clauses; c++) begin
            clause_status(clauses_i[c], vals_i, sat_d[c], fals_d[c], unit_d[c],
                          uvar_d[c], upos_d[c]);
        end
    end

    always_ff @(posedge clk) begin
        if (go_i) begin
            sat_q  <= sat_d;
            fals_q <= fals_d;
            unit_q <= unit_d;
            upos_q <= upos_d;
            uvar_q <= uvar_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= go_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 2 reduction over all clauses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        unit_var_d = '0;
        unit_pos_d = 1'b0;
        for (int c = solver_dims_pkg::num_clauses - 1; c >= 0; c--) begin
            if (unit_q[c]) begin
                unit_var_d = uvar_q[c];                 // descending scan leaves the lowest slot
                unit_pos_d = upos_q[c];
            end
        end
    end

    assign unit_ok = (|unit_q) & ~(|fals_q);            // a conflict masks the implication

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_o       <= 1'b0;
            all_sat_o    <= 1'b0;
            conflict_o   <= 1'b0;
            unit_valid_o <= 1'b0;
            unit_var_o   <= '0;
            unit_val_o   <= clause_types_pkg::val_unassigned;
        end else begin
            done_o <= s1_valid_q;
            if (s1_valid_q) begin
                all_sat_o    <= &sat_q;
                conflict_o   <= |fals_q;
                unit_valid_o <= unit_ok;
                unit_var_o   <= unit_var_d;
                unit_val_o   <= !unit_ok ? clause_types_pkg::val_unassigned :
                                unit_pos_d ? clause_types_pkg::val_true :
                                clause_types_pkg::val_false;
            end
        end
    end

endmodule

`default_nettype wire

// File: clause_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clause slot registers with write, clear, registered read-back
// and literal count on write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module clause_store (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          we_i,
    input  clause_types_pkg::clause_idx_t idx_i,
    input  clause_types_pkg::lit_mask_t   data_i,
    input  logic                          clear_we_i,
    input  clause_types_pkg::clause_idx_t clear_idx_i,
    input  logic                          rd_en_i,
    input  clause_types_pkg::clause_idx_t rd_idx_i,
    output clause_types_pkg::lit_mask_t   clauses_o [solver_dims_pkg::num_clauses],
    output clause_types_pkg::clause_len_t lens_o [solver_dims_pkg::num_clauses],
    output logic                          rd_valid_o,
    output clause_types_pkg::lit_mask_t   rd_clause_o
);

    clause_types_pkg::lit_mask_t   mask_q [solver_dims_pkg::num_clauses];
    clause_types_pkg::clause_len_t len_q [solver_dims_pkg::num_clauses];
    logic                          wr_en;
    clause_types_pkg::clause_idx_t wr_idx;
    clause_types_pkg::lit_mask_t   wr_data;

    function automatic clause_types_pkg::clause_len_t lit_count(
        input clause_types_pkg::lit_mask_t mask
    );
        logic [solver_dims_pkg::len_w:0] cnt;
        cnt = '0;
        for (int b = 0; b < $bits(mask); b++) begin
            cnt = cnt + mask[b];
        end
        return cnt[solver_dims_pkg::len_w] ? '1 : cnt[solver_dims_pkg::len_w-1:0];
    endfunction

    // clear and caller writes never overlap, the clear ends before ready
    assign wr_en   = we_i | clear_we_i;
    assign wr_idx  = clear_we_i ? clear_idx_i : idx_i;
    assign wr_data = clear_we_i ? '0 : data_i;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mask_q[wr_idx] <= wr_data;
            len_q[wr_idx]  <= lit_count(wr_data);
        end
        if (rd_en_i) begin
            rd_clause_o <= (wr_en && (wr_idx == rd_idx_i)) ? wr_data : mask_q[rd_idx_i];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_i;
        end
    end

    assign clauses_o = mask_q;
    assign lens_o    = len_q;

endmodule

`default_nettype wire

// File: clause_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// literal mask and variable value encodings, vector typedefs
// and the controller state encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package clause_types_pkg;

    // bit 2v is the positive literal of variable v, bit 2v+1 the negative one
    typedef logic [2*solver_dims_pkg::num_vars-1:0] lit_mask_t;

    // bits 2v+1:2v hold the value code of variable v
    typedef logic [2*solver_dims_pkg::num_vars-1:0] var_vals_t;

    typedef logic [solver_dims_pkg::len_w-1:0]        clause_len_t;
    typedef logic [solver_dims_pkg::clause_idx_w-1:0] clause_idx_t;
    typedef logic [solver_dims_pkg::var_idx_w-1:0]    var_idx_t;

    localparam logic [1:0] val_unassigned = 2'b00;
    localparam logic [1:0] val_true       = 2'b01;
    localparam logic [1:0] val_false      = 2'b10;   // code 11 reads as unassigned

    typedef enum logic {
        st_clear,                                       // zeroing the slots after reset
        st_run
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: learnt_slot_pick.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// replacement target for learnt clauses from the longest learnt slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module learnt_slot_pick (
    input  clause_types_pkg::clause_len_t lens_i [solver_dims_pkg::num_clauses],
    output clause_types_pkg::clause_idx_t pick_idx_o
);

    clause_types_pkg::clause_idx_t lo_idx;
    clause_types_pkg::clause_idx_t hi_idx;

    // absolute index of learnt slot k in the upper half
    function automatic clause_types_pkg::clause_idx_t learnt_slot(input int k);
        return clause_types_pkg::clause_idx_t'(
            solver_dims_pkg::num_clauses - solver_dims_pkg::num_learnt + k);
    endfunction

    always_comb begin
        // the right side only wins when strictly longer, so ties keep the lower slot
        lo_idx = (lens_i[learnt_slot(1)] > lens_i[learnt_slot(0)]) ?
                 learnt_slot(1) : learnt_slot(0);
        hi_idx = (lens_i[learnt_slot(3)] > lens_i[learnt_slot(2)]) ?
                 learnt_slot(3) : learnt_slot(2);

        pick_idx_o = (lens_i[hi_idx] > lens_i[lo_idx]) ? hi_idx : lo_idx;
    end

endmodule

`default_nettype wire

// File: solver_dims_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// counts and widths of the clause array and of the variable set
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package solver_dims_pkg;

    localparam int num_clauses  = 8;                     // clause slots in the array
    localparam int num_vars     = 8;
    localparam int num_learnt   = 4;                     // learnt clauses live in the upper slots

    localparam int clause_idx_w = $clog2(num_clauses);
    localparam int var_idx_w    = $clog2(num_vars);

    // literal count of a clause, a full mask of 16 literals saturates at 15
    localparam int len_w        = 4;

endpackage

`default_nettype wire

// File: tb_clause_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the clause array with clock, reset, random stimulus,
// shadow clause model and result checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module tb_clause_array;
    timeunit 1ns;
    timeprecision 1ps;

    logic                          clk;
    logic                          rst_n_i;
    logic                          wr_i;
    clause_types_pkg::clause_idx_t wr_idx_i;
    logic                          learnt_i;
    clause_types_pkg::lit_mask_t   clause_i;
    logic                          rd_i;
    clause_types_pkg::clause_idx_t rd_idx_i;
    logic                          eval_i;
    clause_types_pkg::var_vals_t   var_vals_i;
    logic                          ready_o;
    logic                          rd_valid_o;
    clause_types_pkg::lit_mask_t   rd_clause_o;
    logic                          done_o;
    logic                          all_sat_o;
    logic                          conflict_o;
    logic                          unit_valid_o;
    clause_types_pkg::var_idx_t    unit_var_o;
    logic [1:0]                    unit_val_o;

    clause_types_pkg::lit_mask_t   shadow [solver_dims_pkg::num_clauses];
    logic [7:0]                    eval_exp_q [$];     // {all_sat, conflict, unit_valid, var, val}
    int                            eval_due_q [$];
    clause_types_pkg::lit_mask_t   rd_exp_q [$];
    int                            rd_due_q [$];
    int                            cyc = 0;
    int                            errors = 0;
    int                            checks = 0;
    int                            last_slot = 0;
    int unsigned                   seed = 32'hcbfffc9d;
    bit                            ready_ok;

    clause_array_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int lit_len(input clause_types_pkg::lit_mask_t mask);
        return ($countones(mask) > 15) ? 15 : $countones(mask);
    endfunction

    function automatic int expected_pick();
        int best;
        best = solver_dims_pkg::num_clauses - solver_dims_pkg::num_learnt;
        for (int s = best + 1; s < solver_dims_pkg::num_clauses; s++) begin
            if (lit_len(shadow[s]) > lit_len(shadow[best])) best = s;   // strict, lower wins ties
        end
        return best;
    endfunction

    function automatic logic [7:0] expected_eval(input clause_types_pkg::var_vals_t vals);
        logic       all_sat;
        logic       conflict;
        logic       uv;
        logic       any_true;
        logic [2:0] uvar;
        logic [2:0] ovar;
        logic [1:0] uval;
        logic [1:0] code;
        logic       opos;
        int         n_open;
        all_sat  = 1'b1;
        conflict = 1'b0;
        uv       = 1'b0;
        uvar     = '0;
        uval     = clause_types_pkg::val_unassigned;
        for (int c = 0; c < solver_dims_pkg::num_clauses; c++) begin
            any_true = 1'b0;
            n_open   = 0;
            ovar     = '0;
            opos     = 1'b0;
            for (int v = 0; v < solver_dims_pkg::num_vars; v++) begin
                code = vals[2*v +: 2];
                if (code == clause_types_pkg::val_true && shadow[c][2*v]) any_true = 1'b1;
                if (code == clause_types_pkg::val_false && shadow[c][2*v+1]) any_true = 1'b1;
                if (code != clause_types_pkg::val_true && code != clause_types_pkg::val_false) begin
                    n_open = n_open + shadow[c][2*v] + shadow[c][2*v+1];
                    if (shadow[c][2*v+1]) begin
                        ovar = 3'(v);
                        opos = 1'b0;
                    end
                    if (shadow[c][2*v]) begin
                        ovar = 3'(v);
                        opos = 1'b1;
                    end
                end
            end
            if (!any_true && shadow[c] != '0) begin
                all_sat = 1'b0;
                if (n_open == 0) begin
                    conflict = 1'b1;
                end else if (n_open == 1 && !uv) begin
                    uv   = 1'b1;                                 // lowest unit clause only
                    uvar = ovar;
                    uval = opos ? clause_types_pkg::val_true : clause_types_pkg::val_false;
                end
            end
        end
        if (conflict) uv = 1'b0;
        return {all_sat, conflict, uv, uvar, uval};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic clause_types_pkg::lit_mask_t rand_mask();
        clause_types_pkg::lit_mask_t m;
        int                          n;
        m = '0;
        n = 1 + $urandom_range(3, 0);                        // mostly short clauses
        if ($urandom_range(7, 0) == 0) n = n + 4;
        repeat (n) m[$urandom_range(15, 0)] = 1'b1;
        return m;
    endfunction

    function automatic clause_types_pkg::var_vals_t rand_vals();
        clause_types_pkg::var_vals_t vals;
        for (int v = 0; v < solver_dims_pkg::num_vars; v++) begin
            case ($urandom_range(2, 0))
                0:       vals[2*v +: 2] = clause_types_pkg::val_unassigned;
                1:       vals[2*v +: 2] = clause_types_pkg::val_true;
                default: vals[2*v +: 2] = clause_types_pkg::val_false;
            endcase
        end
        return vals;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %0d ns %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_outputs();
        logic [7:0]                  exp;
        clause_types_pkg::lit_mask_t rexp;
        checks += 2;
        if (eval_due_q.size() > 0 && eval_due_q[0] <= cyc) begin
            exp = eval_exp_q.pop_front();
            void'(eval_due_q.pop_front());
            assert (done_o === 1'b1) else begin
                errors++;
                $display("done_o did not pulse two cycles after an accepted eval_i at %0d ns", $time);
            end
            check_value("all_sat_o", exp[7], all_sat_o);
            check_value("conflict_o", exp[6], conflict_o);
            check_value("unit_valid_o", exp[5], unit_valid_o);
            if (exp[5]) begin
                check_value("unit_var_o", exp[4:2], unit_var_o);
                check_value("unit_val_o", exp[1:0], unit_val_o);
            end
        end else begin
            assert (done_o === 1'b0) else begin
                errors++;
                $display("done_o pulsed with no evaluation pending at %0d ns", $time);
            end
        end
        if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
            rexp = rd_exp_q.pop_front();
            void'(rd_due_q.pop_front());
            assert (rd_valid_o === 1'b1) else begin
                errors++;
                $display("rd_valid_o did not follow an accepted rd_i at %0d ns", $time);
            end
            check_value("rd_clause_o", rexp, rd_clause_o);
        end else begin
            assert (rd_valid_o === 1'b0) else begin
                errors++;
                $display("rd_valid_o high with no read pending at %0d ns", $time);
            end
        end
    endtask

    // one cycle: check what the last edges produced, then drive and update the model
    task automatic step(input bit do_wr, input bit do_lrn, input bit do_rd, input int rd_slot,
                        input bit do_ev);
        int slot;
        @(negedge clk);
        check_outputs();
        wr_i       = do_wr;
        learnt_i   = do_lrn;
        wr_idx_i   = clause_types_pkg::clause_idx_t'($urandom_range(7, 0));
        clause_i   = rand_mask();
        rd_i       = do_rd;
        rd_idx_i   = clause_types_pkg::clause_idx_t'((rd_slot < 0) ? $urandom_range(7, 0) : rd_slot);
        eval_i     = do_ev;
        var_vals_i = rand_vals();
        if (do_ev) begin
            eval_exp_q.push_back(expected_eval(var_vals_i));   // contents before this edge's write
            eval_due_q.push_back(cyc + 2);
        end
        if (do_wr) begin
            slot         = do_lrn ? expected_pick() : int'(wr_idx_i);
            shadow[slot] = clause_i;
            last_slot    = slot;
        end
        if (do_rd) begin
            rd_exp_q.push_back(shadow[rd_idx_i]);              // same-slot write is forwarded
            rd_due_q.push_back(cyc + 1);
        end
    endtask

    task automatic wait_ready(output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < 20) begin
            @(negedge clk);
            n++;
            ok = (ready_o === 1'b1);
        end
        if (ok) begin
            check_value("ready_o latency", 8, n);
        end else begin
            errors++;
            $display("ready_o did not rise within 20 cycles after reset release");
        end
    endtask

    initial begin
        void'($urandom(seed));
        rst_n_i    = 1'b0;
        wr_i       = 1'b0;
        wr_idx_i   = '0;
        learnt_i   = 1'b0;
        clause_i   = '0;
        rd_i       = 1'b0;
        rd_idx_i   = '0;
        eval_i     = 1'b0;
        var_vals_i = '0;
        for (int s = 0; s < solver_dims_pkg::num_clauses; s++) shadow[s] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_value("ready_o", 1'b0, ready_o);
        check_value("rd_valid_o", 1'b0, rd_valid_o);
        check_value("done_o", 1'b0, done_o);
        check_value("unit_valid_o", 1'b0, unit_valid_o);
        rst_n_i = 1'b1;
        wait_ready(ready_ok);
        if (ready_ok) begin
            for (int s = 0; s < solver_dims_pkg::num_clauses; s++) step(0, 0, 1, s, 0);
            step(0, 0, 0, -1, 1);                              // empty array is all satisfied
            repeat (40) begin
                step(1, 0, $urandom_range(1, 0), -1, 0);
                step(0, 0, 1, last_slot, 0);
            end
            repeat (16) begin
                step(1, 1, 0, -1, 0);
                step(0, 0, 1, last_slot, 0);
            end
            for (int s = 4; s < solver_dims_pkg::num_clauses; s++) step(0, 0, 1, s, 0);
            repeat (40) step(0, 0, 0, -1, 1);
            repeat (60) begin
                step($urandom_range(1, 0), $urandom_range(1, 0), $urandom_range(1, 0), -1, 1);
            end
            for (int k = 0; k < 10 && (eval_due_q.size() > 0 || rd_due_q.size() > 0); k++) begin
                step(0, 0, 0, -1, 0);
            end
            if (eval_due_q.size() > 0 || rd_due_q.size() > 0) begin
                errors++;
                $display("results still pending after the drain timeout");
            end
        end
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
solver_dims_pkg.sv
clause_types_pkg.sv
learnt_slot_pick.sv
clause_ctrl.sv
clause_store.sv
clause_eval.sv
clause_array_top.sv
clause_array_assert.sv
tb_clause_array.sv
